// ==== rtl/tdc_shot_pkg.sv ====
package tdc_shot_pkg;

    // --------------------------------------------------
    // TDC result format
    // --------------------------------------------------

    // Raw result width from the TDC
    localparam int unsigned TDC_WIDTH = 19;

    // Stored timestamps keep the low bits only
    localparam int unsigned TIME_WIDTH = 16;

    localparam int unsigned CHAN_WIDTH = 3;

    // Echo photodiode sits on channel 0
    localparam logic [CHAN_WIDTH-1:0] ECHO_CHANNEL = 3'd0;

    // --------------------------------------------------
    // Ranging limits
    // --------------------------------------------------

    // Results at or above this are dropped before tracking
    localparam logic [TDC_WIDTH-1:0] RANGE_LIMIT = 19'd20000;

    // Reported times beyond this flag the shot as bad
    localparam logic [TIME_WIDTH-1:0] MAX_VALID_TIME = 16'd2000;

    // --------------------------------------------------
    // Counters
    // --------------------------------------------------

    localparam int unsigned CNT_WIDTH = 4;

    // Hit counters stick at all ones
    localparam logic [CNT_WIDTH-1:0] CNT_MAX = '1;

    localparam int unsigned TIMEOUT_WIDTH = 16;

    // Idle cycles before the strobe is disarmed, kept short for simulation
    localparam logic [TIMEOUT_WIDTH-1:0] SHOT_TIMEOUT = 16'd1000;

    // Shot counter wraps
    localparam int unsigned SHOT_CNT_WIDTH = 8;

endpackage

// ==== rtl/laser_shot_timer.sv ====
`timescale 1ns/1ns

module laser_shot_timer (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_laser_str,
    output logic o_shot_start,
    output logic o_shot_clear
);

    import tdc_shot_pkg::*;

    logic                     str_d;
    logic                     armed;
    logic [TIMEOUT_WIDTH-1:0] idle_cnt;
    logic                     str_rise;

    // --------------------------------------------------
    // Strobe edge detect
    // --------------------------------------------------

    assign str_rise = i_laser_str & ~str_d;

    // Every rising edge opens a new shot window
    assign o_shot_clear = str_rise;

    // Only an armed edge closes a shot with a report
    assign o_shot_start = str_rise & armed;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            str_d <= 1'b0;
        end else begin
            str_d <= i_laser_str;
        end
    end

    // --------------------------------------------------
    // Idle timeout and armed state
    // --------------------------------------------------

    // Counts low strobe cycles, holds at the timeout
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idle_cnt <= '0;
        end else if (i_laser_str) begin
            idle_cnt <= '0;
        end else if (idle_cnt != SHOT_TIMEOUT) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // Strobe wins so a single pulse after a timeout still re-arms
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            armed <= 1'b0;
        end else if (i_laser_str) begin
            armed <= 1'b1;
        end else if (idle_cnt == SHOT_TIMEOUT) begin
            armed <= 1'b0;
        end
    end

    // A strobe edge lasts a single cycle
    a_clear_single : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_shot_clear |=> !o_shot_clear
    );

    a_idle_bounded : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) idle_cnt <= SHOT_TIMEOUT
    );

endmodule

// ==== rtl/tdc_hit_filter.sv ====
`timescale 1ns/1ns

module tdc_hit_filter (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_tdc_valid,
    input  logic                               i_tdc_edge,
    input  logic [tdc_shot_pkg::CHAN_WIDTH-1:0] i_tdc_chan,
    input  logic [tdc_shot_pkg::TDC_WIDTH-1:0]  i_tdc_time,
    output logic                               o_rise_hit,
    output logic                               o_fall_hit,
    output logic [tdc_shot_pkg::TIME_WIDTH-1:0] o_hit_time
);

    import tdc_shot_pkg::*;

    logic chan_ok;
    logic range_ok;
    logic is_hit;

    // --------------------------------------------------
    // Qualification
    // --------------------------------------------------

    assign chan_ok  = (i_tdc_chan == ECHO_CHANNEL);
    assign range_ok = (i_tdc_time < RANGE_LIMIT);

    // Anything off channel or out of range never reaches the trackers
    assign is_hit = i_tdc_valid & chan_ok & range_ok;

    // --------------------------------------------------
    // Output register stage
    // --------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rise_hit <= 1'b0;
            o_fall_hit <= 1'b0;
        end else begin
            // Edge id 1 is rise, 0 is fall
            o_rise_hit <= is_hit & i_tdc_edge;
            o_fall_hit <= is_hit & ~i_tdc_edge;
        end
    end

    // Time only moves with a qualified hit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hit_time <= '0;
        end else if (is_hit) begin
            o_hit_time <= i_tdc_time[TIME_WIDTH-1:0];
        end
    end

    a_hit_exclusive : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) $onehot0({o_rise_hit, o_fall_hit})
    );

endmodule

// ==== rtl/edge_min_tracker.sv ====
`timescale 1ns/1ns

module edge_min_tracker (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_clear,
    input  logic                               i_hit,
    input  logic [tdc_shot_pkg::TIME_WIDTH-1:0] i_hit_time,
    output logic [tdc_shot_pkg::TIME_WIDTH-1:0] o_min_time,
    output logic [tdc_shot_pkg::CNT_WIDTH-1:0]  o_hit_cnt
);

    import tdc_shot_pkg::*;

    logic first_hit;
    logic earlier;
    logic cnt_full;

    // --------------------------------------------------
    // Compare against the running minimum
    // --------------------------------------------------

    // Empty shot takes the first time unconditionally
    assign first_hit = (o_hit_cnt == '0);
    assign earlier   = (i_hit_time < o_min_time);
    assign cnt_full  = (o_hit_cnt == CNT_MAX);

    // --------------------------------------------------
    // Hit counter
    // --------------------------------------------------

    // Clear wins over a coincident hit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hit_cnt <= '0;
        end else if (i_clear) begin
            o_hit_cnt <= '0;
        end else if (i_hit && !cnt_full) begin
            o_hit_cnt <= o_hit_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Earliest timestamp
    // --------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_min_time <= '0;
        end else if (i_clear) begin
            o_min_time <= '0;
        end else if (i_hit && (first_hit || earlier)) begin
            o_min_time <= i_hit_time;
        end
    end

    // Saturated count stays put until the next shot
    a_cnt_no_wrap : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (cnt_full && !i_clear) |=> (o_hit_cnt == CNT_MAX)
    );

endmodule

// ==== rtl/shot_report.sv ====
`timescale 1ns/1ns

module shot_report (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_shot_start,
    input  logic [tdc_shot_pkg::TIME_WIDTH-1:0]     i_rise_time,
    input  logic [tdc_shot_pkg::TIME_WIDTH-1:0]     i_fall_time,
    input  logic [tdc_shot_pkg::CNT_WIDTH-1:0]      i_rise_cnt,
    input  logic [tdc_shot_pkg::CNT_WIDTH-1:0]      i_fall_cnt,
    output logic                                   o_shot_valid,
    output logic                                   o_shot_error,
    output logic [tdc_shot_pkg::TIME_WIDTH-1:0]     o_rise_time,
    output logic [tdc_shot_pkg::TIME_WIDTH-1:0]     o_fall_time,
    output logic [tdc_shot_pkg::TIME_WIDTH-1:0]     o_pulse_width,
    output logic [tdc_shot_pkg::SHOT_CNT_WIDTH-1:0] o_shot_count
);

    import tdc_shot_pkg::*;

    logic                  rise_seen;
    logic                  fall_seen;
    logic [TIME_WIDTH-1:0] rise_sel;
    logic [TIME_WIDTH-1:0] fall_sel;
    logic [TIME_WIDTH-1:0] width_calc;
    logic                  error_calc;

    // --------------------------------------------------
    // Record of the shot that is ending
    // --------------------------------------------------

    assign rise_seen = (i_rise_cnt != '0);
    assign fall_seen = (i_fall_cnt != '0);

    always_comb begin
        // Unseen edges report as zero
        rise_sel = rise_seen ? i_rise_time : '0;
        fall_sel = fall_seen ? i_fall_time : '0;

        // Width only for a well ordered pulse
        if (rise_seen && fall_seen && (fall_sel >= rise_sel)) begin
            width_calc = fall_sel - rise_sel;
        end else begin
            width_calc = '0;
        end

        error_calc = !rise_seen || !fall_seen ||
                     (rise_sel > MAX_VALID_TIME) || (fall_sel > MAX_VALID_TIME);
    end

    // --------------------------------------------------
    // Report registers
    // --------------------------------------------------

    // Single cycle strobe, one cycle after shot start
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_shot_valid <= 1'b0;
        end else begin
            o_shot_valid <= i_shot_start;
        end
    end

    // Record holds until the next report
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_shot_error  <= 1'b0;
            o_rise_time   <= '0;
            o_fall_time   <= '0;
            o_pulse_width <= '0;
        end else if (i_shot_start) begin
            o_shot_error  <= error_calc;
            o_rise_time   <= rise_sel;
            o_fall_time   <= fall_sel;
            o_pulse_width <= width_calc;
        end
    end

    // Running count of reports, wraps
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_shot_count <= '0;
        end else if (i_shot_start) begin
            o_shot_count <= o_shot_count + 1'b1;
        end
    end

    // Strobe must drop between shots
    a_valid_pulse : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_shot_valid |=> !o_shot_valid
    );

endmodule

// ==== rtl/tdc_shot_top.sv ====
`timescale 1ns/1ns

module tdc_shot_top (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_laser_str,
    input  logic                                   i_tdc_valid,
    input  logic                                   i_tdc_edge,
    input  logic [tdc_shot_pkg::CHAN_WIDTH-1:0]     i_tdc_chan,
    input  logic [tdc_shot_pkg::TDC_WIDTH-1:0]      i_tdc_time,
    output logic                                   o_shot_valid,
    output logic                                   o_shot_error,
    output logic [tdc_shot_pkg::TIME_WIDTH-1:0]     o_rise_time,
    output logic [tdc_shot_pkg::TIME_WIDTH-1:0]     o_fall_time,
    output logic [tdc_shot_pkg::TIME_WIDTH-1:0]     o_pulse_width,
    output logic [tdc_shot_pkg::SHOT_CNT_WIDTH-1:0] o_shot_count
);

    import tdc_shot_pkg::*;

    logic                  shot_start;
    logic                  shot_clear;
    logic                  rise_hit;
    logic                  fall_hit;
    logic [TIME_WIDTH-1:0] hit_time;
    logic [TIME_WIDTH-1:0] rise_min;
    logic [TIME_WIDTH-1:0] fall_min;
    logic [CNT_WIDTH-1:0]  rise_cnt;
    logic [CNT_WIDTH-1:0]  fall_cnt;

    // --------------------------------------------------
    // Shot framing and hit qualification
    // --------------------------------------------------

    laser_shot_timer u_timer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_laser_str  (i_laser_str),
        .o_shot_start (shot_start),
        .o_shot_clear (shot_clear)
    );

    tdc_hit_filter u_filter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tdc_valid (i_tdc_valid),
        .i_tdc_edge  (i_tdc_edge),
        .i_tdc_chan  (i_tdc_chan),
        .i_tdc_time  (i_tdc_time),
        .o_rise_hit  (rise_hit),
        .o_fall_hit  (fall_hit),
        .o_hit_time  (hit_time)
    );

    // --------------------------------------------------
    // Per edge trackers and report
    // --------------------------------------------------

    edge_min_tracker u_rise_trk (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_clear    (shot_clear),
        .i_hit      (rise_hit),
        .i_hit_time (hit_time),
        .o_min_time (rise_min),
        .o_hit_cnt  (rise_cnt)
    );

    edge_min_tracker u_fall_trk (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_clear    (shot_clear),
        .i_hit      (fall_hit),
        .i_hit_time (hit_time),
        .o_min_time (fall_min),
        .o_hit_cnt  (fall_cnt)
    );

    shot_report u_report (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_shot_start  (shot_start),
        .i_rise_time   (rise_min),
        .i_fall_time   (fall_min),
        .i_rise_cnt    (rise_cnt),
        .i_fall_cnt    (fall_cnt),
        .o_shot_valid  (o_shot_valid),
        .o_shot_error  (o_shot_error),
        .o_rise_time   (o_rise_time),
        .o_fall_time   (o_fall_time),
        .o_pulse_width (o_pulse_width),
        .o_shot_count  (o_shot_count)
    );

endmodule

// ==== dv/tdc_shot_tb.sv ====
`timescale 1ns/1ns

module tdc_shot_tb;

    import tdc_shot_pkg::*;

    localparam int CLK_PERIOD = 20;
    // Per test cycle budgets: arming, minimum, filtering, rules, random
    localparam int WATCHDOG_CYCLES = (int'(SHOT_TIMEOUT) + 100) + 100 + 150 + 150 + 6500 + 500;

    logic                      clk;
    logic                      rst_n;
    logic                      laser_str;
    logic                      tdc_valid;
    logic                      tdc_edge;
    logic [CHAN_WIDTH-1:0]     tdc_chan;
    logic [TDC_WIDTH-1:0]      tdc_time;
    logic                      shot_valid;
    logic                      shot_error;
    logic [TIME_WIDTH-1:0]     rise_time;
    logic [TIME_WIDTH-1:0]     fall_time;
    logic [TIME_WIDTH-1:0]     pulse_width;
    logic [SHOT_CNT_WIDTH-1:0] shot_count;

    int err_cnt;
    int check_cnt;
    int test_cnt;
    int test_err_base;

    // Reference model of the shot in progress
    int m_rise_min;
    int m_rise_cnt;
    int m_fall_min;
    int m_fall_cnt;
    int m_shot_cnt;
    bit m_armed;

    tdc_shot_top dut0 (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_laser_str   (laser_str),
        .i_tdc_valid   (tdc_valid),
        .i_tdc_edge    (tdc_edge),
        .i_tdc_chan    (tdc_chan),
        .i_tdc_time    (tdc_time),
        .o_shot_valid  (shot_valid),
        .o_shot_error  (shot_error),
        .o_rise_time   (rise_time),
        .o_fall_time   (fall_time),
        .o_pulse_width (pulse_width),
        .o_shot_count  (shot_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------
    // Checking and reference model
    // --------------------------------------------------

    task compare_val(input string what, input int got, input int exp);
        check_cnt++;
        assert (got == exp) else begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // Only valid echo results below the range limit count
    task model_hit(input logic valid, input logic edge_id, input int chan, input int t);
        if (valid && chan == ECHO_CHANNEL && t < RANGE_LIMIT) begin
            if (edge_id) begin
                if (m_rise_cnt == 0 || t < m_rise_min) begin
                    m_rise_min = t;
                end
                if (m_rise_cnt < 15) begin
                    m_rise_cnt++;
                end
            end else begin
                if (m_fall_cnt == 0 || t < m_fall_min) begin
                    m_fall_min = t;
                end
                if (m_fall_cnt < 15) begin
                    m_fall_cnt++;
                end
            end
        end
    endtask

    task send_result(input logic valid, input logic edge_id, input int chan, input int t);
        @(negedge clk);
        tdc_valid = valid;
        tdc_edge  = edge_id;
        tdc_chan  = chan[CHAN_WIDTH-1:0];
        tdc_time  = t[TDC_WIDTH-1:0];
        @(negedge clk);
        tdc_valid = 1'b0;
        model_hit(valid, edge_id, chan, t);
    endtask

    // One strobe pulse, two cycles high, then the report window
    task fire_strobe;
        int exp_rise;
        int exp_fall;
        int exp_width;
        int exp_count;
        int seen;
        bit exp_err;
        bit exp_report;
        exp_rise   = (m_rise_cnt != 0) ? m_rise_min : 0;
        exp_fall   = (m_fall_cnt != 0) ? m_fall_min : 0;
        exp_width  = 0;
        if (m_rise_cnt != 0 && m_fall_cnt != 0 && exp_fall >= exp_rise) begin
            exp_width = exp_fall - exp_rise;
        end
        exp_err    = (m_rise_cnt == 0) || (m_fall_cnt == 0) ||
                     (exp_rise > MAX_VALID_TIME) || (exp_fall > MAX_VALID_TIME);
        exp_count  = (m_shot_cnt + 1) % (1 << SHOT_CNT_WIDTH);
        exp_report = m_armed;
        seen       = 0;
        repeat (3) @(negedge clk);
        laser_str = 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (shot_valid) begin
                seen++;
                if (seen == 1 && exp_report) begin
                    compare_val("rise time", rise_time, exp_rise);
                    compare_val("fall time", fall_time, exp_fall);
                    compare_val("pulse width", pulse_width, exp_width);
                    compare_val("shot error", shot_error, exp_err);
                    compare_val("shot count", shot_count, exp_count);
                end
            end
            if (i == 1) begin
                laser_str = 1'b0;
            end
        end
        check_cnt++;
        assert (seen == (exp_report ? 1 : 0)) else begin
            $display("Wrong number of shot reports at %0t ns: saw %0d, expected %0d",
                     $time, seen, exp_report ? 1 : 0);
            err_cnt++;
        end
        if (exp_report) begin
            m_shot_cnt = exp_count;
        end
        // Every rising edge starts a fresh shot
        m_rise_min = 0;
        m_rise_cnt = 0;
        m_fall_min = 0;
        m_fall_cnt = 0;
        m_armed    = 1'b1;
    endtask

    task idle_wait(input int cycles);
        repeat (cycles) @(negedge clk);
        if (cycles > SHOT_TIMEOUT) begin
            m_armed = 1'b0;
        end
    endtask

    task finish_test(input string name);
        test_cnt++;
        $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task check_arming;
        // First strobe only arms
        fire_strobe();
        idle_wait(10);
        fire_strobe();
        // Long idle disarms again
        idle_wait(int'(SHOT_TIMEOUT) + 20);
        fire_strobe();
        finish_test("arming");
    endtask

    task capture_minimum;
        int rise_q[$];
        int fall_q[$];
        int k;
        rise_q = '{450, 312, 389, 520};
        fall_q = '{610, 700, 655, 598};
        while (rise_q.size() + fall_q.size() > 0) begin
            if (fall_q.size() == 0 || (rise_q.size() != 0 && $urandom_range(0, 1) == 1)) begin
                k = $urandom_range(0, rise_q.size() - 1);
                send_result(1'b1, 1'b1, ECHO_CHANNEL, rise_q[k]);
                rise_q.delete(k);
            end else begin
                k = $urandom_range(0, fall_q.size() - 1);
                send_result(1'b1, 1'b0, ECHO_CHANNEL, fall_q[k]);
                fall_q.delete(k);
            end
        end
        fire_strobe();
        finish_test("minimum capture");
    endtask

    task filter_junk;
        send_result(1'b1, 1'b1, 0, 400);
        send_result(1'b1, 1'b0, 0, 900);
        send_result(1'b1, 1'b1, 2, 100);
        send_result(1'b1, 1'b0, 0, RANGE_LIMIT);
        // Out of range, low bits below the echo rise time
        send_result(1'b1, 1'b1, 0, 65636);
        send_result(1'b0, 1'b1, 0, 50);
        fire_strobe();
        // Shot with nothing but rejected results
        send_result(1'b1, 1'b0, 5, 120);
        send_result(1'b1, 1'b1, 0, 20000);
        send_result(1'b0, 1'b0, 0, 70);
        fire_strobe();
        finish_test("filtering");
    endtask

    task error_rules;
        send_result(1'b1, 1'b1, 0, 300);
        fire_strobe();
        send_result(1'b1, 1'b1, 0, 300);
        send_result(1'b1, 1'b0, 0, 2500);
        fire_strobe();
        send_result(1'b1, 1'b1, 0, 800);
        send_result(1'b1, 1'b0, 0, 600);
        fire_strobe();
        finish_test("error and width rules");
    endtask

    task random_shots;
        int   n_rise;
        int   n_fall;
        int   t;
        int   chan;
        logic valid;
        logic edge_id;
        // Empty shots bring the counter up to its wrap
        while (m_shot_cnt < 240) begin
            fire_strobe();
        end
        repeat (50) begin
            n_rise = $urandom_range(0, 20);
            n_fall = $urandom_range(0, 20);
            while (n_rise + n_fall > 0) begin
                edge_id = (n_fall == 0) || (n_rise != 0 && $urandom_range(0, 1) == 1);
                if (edge_id) begin
                    n_rise--;
                end else begin
                    n_fall--;
                end
                t     = ($urandom_range(0, 7) == 0) ? $urandom_range(20000, 524287)
                                                    : $urandom_range(0, 2200);
                chan  = ($urandom_range(0, 7) == 0) ? $urandom_range(1, 7) : 0;
                valid = ($urandom_range(0, 9) != 0);
                send_result(valid, edge_id, chan, t);
            end
            fire_strobe();
        end
        finish_test("random shots");
    endtask

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        laser_str     = 1'b0;
        tdc_valid     = 1'b0;
        tdc_edge      = 1'b0;
        tdc_chan      = '0;
        tdc_time      = '0;
        err_cnt       = 0;
        check_cnt     = 0;
        test_cnt      = 0;
        test_err_base = 0;
        m_rise_min    = 0;
        m_rise_cnt    = 0;
        m_fall_min    = 0;
        m_fall_cnt    = 0;
        m_shot_cnt    = 0;
        m_armed       = 1'b0;
        void'($urandom(32'hf08a_c49c));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_val("shot valid after reset", shot_valid, 0);
        compare_val("shot error after reset", shot_error, 0);
        compare_val("shot count after reset", shot_count, 0);
        compare_val("pulse width after reset", pulse_width, 0);
        compare_val("rise time after reset", rise_time, 0);
        compare_val("fall time after reset", fall_time, 0);
        check_arming();
        capture_minimum();
        filter_junk();
        error_rules();
        random_shots();
        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/tdc_shot_pkg.sv
rtl/laser_shot_timer.sv
rtl/tdc_hit_filter.sv
rtl/edge_min_tracker.sv
rtl/shot_report.sv
rtl/tdc_shot_top.sv
dv/tdc_shot_tb.sv

// ==== Bender.yml ====
package:
  name: tdc_shot

sources:
  - rtl/tdc_shot_pkg.sv
  - rtl/laser_shot_timer.sv
  - rtl/tdc_hit_filter.sv
  - rtl/edge_min_tracker.sv
  - rtl/shot_report.sv
  - rtl/tdc_shot_top.sv
  - target: simulation
    files:
      - dv/tdc_shot_tb.sv
